// File: hdl/port_backend.sv
`default_nettype none

`include "port_consts.svh"

module port_backend (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        match_end,
    input  switch_port_pkg::sram_addr_t grant_base,
    input  switch_port_pkg::pkt_info_t  new_info,

    output logic                        pop,
    input  switch_port_pkg::buf_word_t  pop_word,
    input  logic                        pop_vld,
    input  switch_port_pkg::buf_level_t level,

    output logic                        desc_vld,
    output switch_port_pkg::pkt_desc_t  desc,

    input  switch_port_pkg::sram_addr_t rd_addr,
    output switch_port_pkg::port_word_t rd_data
);

    import switch_port_pkg::*;

    port_word_t             mem [`PORT_SRAM_DEPTH];
    xfer_state_t            xf_state;
    logic [`PORT_SRAM_AW:0] credit;       // granted words not yet popped.
    logic [`PORT_SRAM_AW:0] credit_add;
    buf_level_t             pend_pkts;    // granted packets not yet fully written.
    buf_level_t             pend_nxt;
    sram_addr_t             wr_addr;
    logic                   hdr_next;     // the next word out of the buffer is a header.
    logic                   done;
    pkt_info_t              cur_info;
    sram_addr_t             cur_base;

    // ~~~~~~~~~~~~~~~~~~~~
    // transfer control
    // ~~~~~~~~~~~~~~~~~~~~

    assign credit_add = match_end ? ({1'b0, new_info.length} + 10'd1) : '0;
    assign done       = pop_vld && pop_word.last;
    assign pend_nxt   = pend_pkts + buf_level_t'(match_end) - buf_level_t'(done);

    // the credit stops us short of a packet whose space is not granted yet.
    assign pop = (xf_state == XF_RUN) && (credit != '0) && (level != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xf_state  <= XF_IDLE;
            credit    <= '0;
            pend_pkts <= '0;
            hdr_next  <= 1'b1;
            desc_vld  <= 1'b0;
        end else begin
            xf_state  <= (pend_nxt != '0) ? XF_RUN : XF_IDLE;
            credit    <= credit + credit_add - {{`PORT_SRAM_AW{1'b0}}, pop};
            pend_pkts <= pend_nxt;
            desc_vld  <= done;
            if (pop_vld) begin
                hdr_next <= pop_word.last;
            end
        end
    end

    // grants are contiguous, so a running transfer already sits at the new base.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
        end else if (match_end && (xf_state == XF_IDLE)) begin
            wr_addr <= grant_base;
        end else if (pop_vld) begin
            wr_addr <= wr_addr + 9'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // packet SRAM and descriptor
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (pop_vld) begin
            mem[wr_addr] <= pop_word.word;
        end
        rd_data <= mem[rd_addr];   // debug port, one cycle of latency.
    end

    always_ff @(posedge clk) begin
        if (pop_vld && hdr_next) begin
            cur_info <= pkt_info_t'(pop_word.word);
            cur_base <= wr_addr;
        end
        if (done) begin
            desc <= '{info: cur_info, base: cur_base};
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_pkt_buffer.sv
`default_nettype none

`include "port_consts.svh"

module port_pkt_buffer (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        push,
    input  switch_port_pkg::buf_word_t  push_word,

    input  logic                        pop,
    output switch_port_pkg::buf_word_t  pop_word,
    output logic                        pop_vld,

    output switch_port_pkg::buf_level_t level
);

    import switch_port_pkg::*;

    buf_word_t               mem [`PORT_BUF_DEPTH];
    logic [`PORT_BUF_AW-1:0] wr_ptr;
    logic [`PORT_BUF_AW-1:0] rd_ptr;

    // ~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~

    // the depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
        if (pop) begin
            pop_word <= mem[rd_ptr];   // registered read, one word per cycle.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // read strobe and fill level
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_vld <= 1'b0;
            level   <= '0;
        end else begin
            pop_vld <= pop;
            case ({push, pop})
                2'b10:   level <= level + 7'd1;
                2'b01:   level <= level - 7'd1;
                default: level <= level;   // both or neither leave the count alone.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_sram_matcher.sv
`default_nettype none

`include "port_consts.svh"

module port_sram_matcher (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        match_enable,
    input  switch_port_pkg::pkt_info_t  new_info,
    output logic                        match_end,
    output switch_port_pkg::sram_addr_t grant_base,

    input  logic                        rel_vld,
    input  switch_port_pkg::pkt_len_t   rel_len
);

    import switch_port_pkg::*;

    logic [`PORT_SRAM_AW:0] free_words;   // one extra bit to hold the full depth.
    logic [`PORT_SRAM_AW:0] need;
    logic [`PORT_SRAM_AW:0] rel_words;
    sram_addr_t             next_base;
    logic                   granted;      // this request has had its match_end.
    logic                   grant;

    // a packet takes its payload plus the header word.
    assign need      = {1'b0, new_info.length} + 10'd1;
    assign rel_words = rel_vld ? ({1'b0, rel_len} + 10'd1) : '0;

    assign grant = match_enable && !granted && (free_words >= need);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_words <= (`PORT_SRAM_AW + 1)'(`PORT_SRAM_DEPTH);
            next_base  <= '0;
            granted    <= 1'b0;
            match_end  <= 1'b0;
        end else begin
            match_end <= grant;
            if (grant) begin
                // wraps at the SRAM depth, which is a power of two.
                next_base  <= next_base + need[`PORT_SRAM_AW-1:0];
                free_words <= free_words + rel_words - need;
            end else begin
                free_words <= free_words + rel_words;
            end
            if (grant) begin
                granted <= 1'b1;
            end else if (!match_enable) begin
                granted <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            grant_base <= next_base;
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_wr_frontend.sv
`default_nettype none

`include "port_consts.svh"

module port_wr_frontend (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        wr_sop,
    input  logic                        wr_vld,
    input  switch_port_pkg::port_word_t wr_data,
    input  logic                        wr_eop,
    output logic                        pause,

    output logic                        push,
    output switch_port_pkg::buf_word_t  push_word,
    input  switch_port_pkg::buf_level_t level,

    output logic                        match_enable,
    output switch_port_pkg::pkt_info_t  new_info,
    input  logic                        match_end
);

    import switch_port_pkg::*;

    wr_state_t wr_state;
    pkt_len_t  pay_cnt;         // payload words taken for the current packet.
    logic      hdr_take;        // header word accepted this cycle.
    logic      last_word;
    logic      buf_near_full;
    logic      hold_for_match;

    // ~~~~~~~~~~~~~~~~~~~~
    // word tagging and pause
    // ~~~~~~~~~~~~~~~~~~~~

    assign hdr_take = (wr_state == WR_HEAD) && wr_vld;

    // the header length closes the packet, and wr_eop closes it as well if it comes early.
    assign last_word = (wr_state == WR_BODY) &&
                       (wr_eop || (pkt_len_t'(pay_cnt + 9'd1) == new_info.length));

    assign push      = wr_vld && ((wr_state == WR_HEAD) || (wr_state == WR_BODY));
    assign push_word = '{word: wr_data, last: last_word};

    assign buf_near_full = level >= buf_level_t'(`PORT_BUF_DEPTH - `PORT_PAUSE_MARGIN);

    // a new packet may not post its header while the previous request is still open.
    assign hold_for_match = match_enable &&
                            ((wr_state == WR_WAIT_MATCH) || ((wr_state == WR_IDLE) && wr_sop));

    assign pause = buf_near_full || hold_for_match;

    // ~~~~~~~~~~~~~~~~~~~~
    // packet FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_sop) begin
                        wr_state <= match_enable ? WR_WAIT_MATCH : WR_HEAD;
                    end
                end
                WR_WAIT_MATCH: begin
                    if (!match_enable) begin
                        wr_state <= WR_HEAD;   // pause has already dropped here.
                    end
                end
                WR_HEAD: begin
                    if (wr_vld) begin
                        wr_state <= WR_BODY;
                    end
                end
                WR_BODY: begin
                    if (wr_vld && last_word) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pay_cnt <= '0;
        end else if (wr_state == WR_HEAD) begin
            pay_cnt <= '0;
        end else if ((wr_state == WR_BODY) && wr_vld) begin
            pay_cnt <= pay_cnt + 9'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // request to the matcher
    // ~~~~~~~~~~~~~~~~~~~~

    // new_info stays put until the next header, so the matcher sees it for the whole request.
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            new_info <= pkt_info_t'(wr_data);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_enable <= 1'b0;
        end else if (hdr_take) begin
            match_enable <= 1'b1;
        end else if (match_end) begin
            match_enable <= 1'b0;              // drops the cycle after the grant.
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_write_top.sv
`default_nettype none

module port_write_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        wr_sop,
    input  logic                        wr_vld,
    input  switch_port_pkg::port_word_t wr_data,
    input  logic                        wr_eop,
    output logic                        pause,

    input  logic                        rel_vld,
    input  switch_port_pkg::pkt_len_t   rel_len,

    output logic                        desc_vld,
    output switch_port_pkg::pkt_desc_t  desc,

    input  switch_port_pkg::sram_addr_t rd_addr,
    output switch_port_pkg::port_word_t rd_data
);

    import switch_port_pkg::*;

    logic       push;
    buf_word_t  push_word;
    buf_level_t level;
    logic       match_enable;
    pkt_info_t  new_info;
    logic       match_end;
    sram_addr_t grant_base;
    logic       pop;
    buf_word_t  pop_word;
    logic       pop_vld;

    // ~~~~~~~~~~~~~~~~~~~~
    // write path
    // ~~~~~~~~~~~~~~~~~~~~

    port_wr_frontend u_frontend (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_vld(wr_vld), .wr_data(wr_data), .wr_eop(wr_eop),
        .pause(pause), .push(push), .push_word(push_word), .level(level),
        .match_enable(match_enable), .new_info(new_info), .match_end(match_end)
    );

    port_pkt_buffer u_buffer (
        .clk(clk), .rst_n(rst_n),
        .push(push), .push_word(push_word),
        .pop(pop), .pop_word(pop_word), .pop_vld(pop_vld), .level(level)
    );

    port_sram_matcher u_matcher (
        .clk(clk), .rst_n(rst_n),
        .match_enable(match_enable), .new_info(new_info),
        .match_end(match_end), .grant_base(grant_base),
        .rel_vld(rel_vld), .rel_len(rel_len)
    );

    port_backend u_backend (
        .clk(clk), .rst_n(rst_n),
        .match_end(match_end), .grant_base(grant_base), .new_info(new_info),
        .pop(pop), .pop_word(pop_word), .pop_vld(pop_vld), .level(level),
        .desc_vld(desc_vld), .desc(desc), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: hdl/switch_port_pkg.sv
`default_nettype none

`include "port_consts.svh"

package switch_port_pkg;

    typedef logic [`PORT_DATA_W-1:0]  port_word_t;
    typedef logic [8:0]               pkt_len_t;   // payload words, header excluded.
    typedef logic [2:0]               prior_t;
    typedef logic [3:0]               dest_port_t;
    typedef logic [`PORT_SRAM_AW-1:0] sram_addr_t;
    typedef logic [`PORT_BUF_AW:0]    buf_level_t; // one extra bit so a full buffer fits.

    // same bit layout as the header word, so a header casts straight into it.
    typedef struct packed {
        pkt_len_t   length;
        prior_t     prior;
        dest_port_t dest;
    } pkt_info_t;

    typedef struct packed {
        port_word_t word;
        logic       last;
    } buf_word_t;

    typedef struct packed {
        pkt_info_t  info;
        sram_addr_t base;
    } pkt_desc_t;

    typedef enum logic [1:0] {WR_IDLE, WR_HEAD, WR_BODY, WR_WAIT_MATCH} wr_state_t;
    typedef enum logic {XF_IDLE, XF_RUN} xfer_state_t;

endpackage

`default_nettype wire

// File: include/port_consts.svh
`ifndef PORT_CONSTS_SVH
`define PORT_CONSTS_SVH

// width of one stream word, header included.
`define PORT_DATA_W       16

// packet buffer between the frontend and the backend.
`define PORT_BUF_DEPTH    64
`define PORT_BUF_AW       6

// shared packet SRAM.
`define PORT_SRAM_DEPTH   512
`define PORT_SRAM_AW      9

// pause goes high once this few buffer slots are left.
// two slots cover the word already on the wire plus one spare.
`define PORT_PAUSE_MARGIN 2

`endif

// File: list.f
+incdir+include
hdl/switch_port_pkg.sv
hdl/port_wr_frontend.sv
hdl/port_pkt_buffer.sv
hdl/port_sram_matcher.sv
hdl/port_backend.sv
hdl/port_write_top.sv
testbench/port_write_checker.sv
testbench/port_write_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the port write path with Verilator and runs the testbench.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f list.f --top-module port_write_tb -o port_write_sim

status=0
output=$(./obj_dir/port_write_sim 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q -F "*** TEST PASSED ***"; then
    exit 0
else
    echo "simulation failed with exit status ${status}"
    exit 1
fi

// File: testbench/port_write_checker.sv
`default_nettype none

`include "port_consts.svh"

module port_write_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        desc_vld,
    input  logic                        pause,
    input  switch_port_pkg::buf_level_t level,
    input  logic                        pop
);

    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // protocol properties
    // ~~~~~~~~~~~~~~~~~~~~

    desc_single: assert property (@(posedge clk) disable iff (!rst_n) desc_vld |=> !desc_vld)
        else $error("desc_vld stayed high for two cycles");

    pause_in_reset: assert property (@(posedge clk) !rst_n |-> !pause)
        else $error("pause is high during reset");

    level_bound: assert property (@(posedge clk) disable iff (!rst_n)
        level <= switch_port_pkg::buf_level_t'(`PORT_BUF_DEPTH))
        else $error("buffer level is above the buffer depth");

    pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> (level != '0))
        else $error("pop raised while the buffer is empty");

endmodule

bind port_write_top port_write_checker u_checker (
    .clk(clk), .rst_n(rst_n), .desc_vld(desc_vld),
    .pause(pause), .level(level), .pop(pop)
);

`default_nettype wire

// File: testbench/port_write_tb.sv
`default_nettype none

`include "port_consts.svh"

module port_write_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import switch_port_pkg::*;

    localparam int N = 12;

    // rel is the number of words handed back before the packet, 0 for none.
    typedef struct packed {
        dest_port_t dest;
        prior_t     prior;
        pkt_len_t   len;
        logic [7:0] gap;
        logic [9:0] rel;
    } entry_t;

    entry_t tbl [N] = '{
        '{4'd1, 3'd0, 9'd4,  8'd2, 10'd0},
        '{4'd2, 3'd1, 9'd60, 8'd0, 10'd0},
        '{4'd3, 3'd2, 9'd60, 8'd3, 10'd0},
        '{4'd4, 3'd3, 9'd60, 8'd0, 10'd0},
        '{4'd5, 3'd4, 9'd60, 8'd1, 10'd0},
        '{4'd6, 3'd5, 9'd60, 8'd0, 10'd0},
        '{4'd7, 3'd6, 9'd60, 8'd0, 10'd0},
        '{4'd8, 3'd7, 9'd60, 8'd5, 10'd0},
        '{4'd9, 3'd0, 9'd60, 8'd0, 10'd0},
        '{4'd10, 3'd1, 9'd50, 8'd0, 10'd0},   // does not fit and has to wait.
        '{4'd11, 3'd2, 9'd8, 8'd0, 10'd101},  // release, then a header while the match is held.
        '{4'd15, 3'd3, 9'd20, 8'd2, 10'd0}
    };
    string names [N] = '{"short_first", "full_a", "full_b", "full_c", "full_d", "full_e",
                         "full_f", "full_g", "full_h", "no_room", "release_held", "after_wrap"};

    logic clk = 1'b0;
    logic rst_n;
    logic wr_sop, wr_vld, wr_eop, pause, rel_vld, desc_vld;
    port_word_t wr_data, rd_data;
    pkt_len_t   rel_len;
    pkt_desc_t  desc;
    sram_addr_t rd_addr;

    logic        pause_seen = 1'b0;   // pause as it stood in the previous cycle.
    logic [31:0] lcg_state = 32'hb779;
    int          model_free = `PORT_SRAM_DEPTH;
    int          model_base = 0;
    int          granted = 0;
    int          desc_cnt = 0;
    int          checked = 0;
    int          pend_q [$];
    int          exp_base [$];
    port_word_t  exp_words [$];
    pkt_desc_t   desc_q [$];

    port_write_top dut (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_vld(wr_vld), .wr_data(wr_data), .wr_eop(wr_eop), .pause(pause),
        .rel_vld(rel_vld), .rel_len(rel_len), .desc_vld(desc_vld), .desc(desc),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic pkt_info_t header_of(input int k);
        pkt_info_t h;
        h.length = tbl[k].len;
        h.prior  = tbl[k].prior;
        h.dest   = tbl[k].dest;
        return h;
    endfunction

    task automatic report_mismatch(input string name, input string what, input int e, input int a);
        $display("MISMATCH %s %s expected %0h actual %0h", name, what, e, a);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic drive(input logic sop, input logic vld, input logic eop,
                         input port_word_t data, input logic rv, input pkt_len_t rl);
        @(negedge clk);
        wr_sop  = sop;
        wr_vld  = vld;
        wr_eop  = eop;
        wr_data = data;
        rel_vld = rv;
        rel_len = rl;
        #1 pause_seen = pause;   // settled by now, inputs changed at the edge.
    endtask

    // grants go strictly in order, and only when length+1 words are free.
    task automatic grant_model();
        int need;
        while (pend_q.size() > 0) begin
            need = int'(tbl[pend_q[0]].len) + 1;
            if (model_free < need) break;
            exp_base.push_back(model_base);
            model_base = (model_base + need) % `PORT_SRAM_DEPTH;
            model_free -= need;
            granted++;
            void'(pend_q.pop_front());
        end
    endtask

    task automatic send_entry(input int k);
        port_word_t w;
        int n;
        logic held;
        repeat (tbl[k].gap) drive(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        if (tbl[k].rel != '0) begin
            drive(1'b0, 1'b0, 1'b0, '0, 1'b1, pkt_len_t'(tbl[k].rel - 10'd1));
            model_free += int'(tbl[k].rel);
        end
        held = (pend_q.size() != 0);   // the previous request is still open.
        pend_q.push_back(k);
        grant_model();
        drive(1'b1, 1'b0, 1'b0, '0, 1'b0, '0);
        if (held) begin
            assert (pause_seen)
                else report_mismatch(names[k], "pause on held match", 1, int'(pause_seen));
        end
        for (n = 0; n <= int'(tbl[k].len); n++) begin
            while (pause_seen) drive(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
            if (n == 0) begin
                w = port_word_t'(header_of(k));
            end else begin
                lcg_state = lcg_next(lcg_state);
                w = lcg_state[31:16];
            end
            exp_words.push_back(w);
            drive(1'b0, 1'b1, n == int'(tbl[k].len), w, 1'b0, '0);
        end
        drive(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        if (pend_q.size() != 0) begin
            repeat (150) @(posedge clk);
            assert (desc_cnt == granted)
                else report_mismatch(names[k], "descriptors before release", granted, desc_cnt);
        end
    endtask

    task automatic check_sram_word(input int k);
        port_word_t w_exp;
        w_exp = exp_words.pop_front();
        assert (rd_data == w_exp)
            else report_mismatch(names[k], "sram word", int'(w_exp), int'(rd_data));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // descriptor capture and check
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (rst_n && desc_vld) begin
            desc_q.push_back(desc);
            desc_cnt++;
        end
    end

    initial begin : desc_checker
        pkt_desc_t  d;
        pkt_info_t  hdr;
        sram_addr_t a;
        int         i;
        forever begin
            while (desc_q.size() == 0) @(negedge clk);
            d = desc_q.pop_front();
            hdr = header_of(checked);
            assert (d.info == hdr)
                else report_mismatch(names[checked], "descriptor info", int'(hdr), int'(d.info));
            assert (int'(d.base) == exp_base[checked])
                else report_mismatch(names[checked], "base", exp_base[checked], int'(d.base));
            a = d.base;
            for (i = 0; i <= int'(hdr.length); i++) begin
                @(negedge clk);
                if (i > 0) check_sram_word(checked);
                rd_addr = a;
                a = a + 9'd1;   // wraps with the SRAM.
            end
            @(negedge clk);
            check_sram_word(checked);
            checked++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n   = 1'b0;
        wr_sop  = 1'b0;
        wr_vld  = 1'b0;
        wr_eop  = 1'b0;
        wr_data = '0;
        rel_vld = 1'b0;
        rel_len = '0;
        rd_addr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < N; k++) begin
            send_entry(k);
        end
        while (checked < N) @(negedge clk);
        assert (desc_cnt == N) else report_mismatch("final", "descriptor count", N, desc_cnt);
        assert (int'(dut.u_matcher.free_words) == model_free)
            else report_mismatch("final", "free words", model_free,
                                 int'(dut.u_matcher.free_words));
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        repeat (N * 200 + 500) @(posedge clk);
        $display("the run hung: not all descriptors were checked in time");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
